//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_ooo_core
FILELIST := project.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := All checks passed

SOURCES  := $(shell cat $(FILELIST))
BIN      := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- hdl/exec_unit.sv
`timescale 1ns/1ps

module exec_unit #(
    parameter int ROB_DEPTH  = 8,
    parameter int UNIT_DEPTH = 2,
    parameter int MUL_CYCLES = 4,
    localparam int TAG_W     = $clog2(ROB_DEPTH),
    localparam int PTR_W     = (UNIT_DEPTH > 1) ? $clog2(UNIT_DEPTH) : 1,
    localparam int CNT_W     = $clog2(UNIT_DEPTH + 1),
    localparam int TIMER_W   = $clog2(MUL_CYCLES + 1)
) (
    input  logic             clk,
    input  logic             rst_n,
    issue_if.unit            issue,
    output logic             result_valid,
    output logic [TAG_W-1:0] result_tag,
    output ooo_pkg::word_t   result_value
);

    typedef enum logic {
        UNIT_IDLE,
        UNIT_BUSY
    } state_t;

    state_t state;

    // local operation queue
    ooo_pkg::opcode_t  uq_opcode [UNIT_DEPTH];
    logic [TAG_W-1:0]  uq_tag [UNIT_DEPTH];
    ooo_pkg::word_t    uq_a [UNIT_DEPTH];
    ooo_pkg::word_t    uq_b [UNIT_DEPTH];
    logic [PTR_W-1:0]  uq_head;
    logic [PTR_W-1:0]  uq_tail;
    logic [CNT_W-1:0]  uq_count;
    logic [TIMER_W-1:0] timer;
    logic              done;

    function automatic ooo_pkg::word_t execute(input ooo_pkg::opcode_t op,
                                               input ooo_pkg::word_t a,
                                               input ooo_pkg::word_t b);
        case (op)
            ooo_pkg::OP_ADD: return a + b;
            ooo_pkg::OP_SUB: return a - b;
            ooo_pkg::OP_AND: return a & b;
            ooo_pkg::OP_XOR: return a ^ b;
            ooo_pkg::OP_SLT: return {31'd0, $signed(a) < $signed(b)};
            ooo_pkg::OP_MUL: return a * b;
            default:         return '0;
        endcase
    endfunction

    // alu ops finish in the cycle at the head, multiply when the timer runs out
    assign done = ((state == UNIT_IDLE) && (uq_count != '0) &&
                   (uq_opcode[uq_head] != ooo_pkg::OP_MUL)) ||
                  ((state == UNIT_BUSY) && (timer == '0));

    // the slot frees together with the result
    assign issue.credit = result_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= UNIT_IDLE;
            timer <= '0;
            result_valid <= 1'b0;
            uq_head <= '0;
            uq_tail <= '0;
            uq_count <= '0;
        end else begin
            result_valid <= done;
            case (state)
                UNIT_IDLE: begin
                    if (uq_count != '0 && uq_opcode[uq_head] == ooo_pkg::OP_MUL) begin
                        state <= UNIT_BUSY;
                        timer <= TIMER_W'(MUL_CYCLES - 2);
                    end
                end
                UNIT_BUSY: begin
                    if (timer == '0) begin
                        state <= UNIT_IDLE;
                    end else begin
                        timer <= timer - 1'b1;
                    end
                end
                default: state <= UNIT_IDLE;
            endcase
            if (issue.valid) begin
                uq_tail <= (uq_tail == PTR_W'(UNIT_DEPTH - 1)) ? '0 : uq_tail + 1'b1;
            end
            if (done) begin
                uq_head <= (uq_head == PTR_W'(UNIT_DEPTH - 1)) ? '0 : uq_head + 1'b1;
            end
            if (issue.valid && !done) begin
                uq_count <= uq_count + 1'b1;
            end else if (!issue.valid && done) begin
                uq_count <= uq_count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue.valid) begin
            uq_opcode[uq_tail] <= issue.opcode;
            uq_tag[uq_tail] <= issue.tag;
            uq_a[uq_tail] <= issue.a;
            uq_b[uq_tail] <= issue.b;
        end
        if (done) begin
            result_tag <= uq_tag[uq_head];
            result_value <= execute(uq_opcode[uq_head], uq_a[uq_head], uq_b[uq_head]);
        end
    end

endmodule : exec_unit

//--- hdl/issue_dispatch.sv
`timescale 1ns/1ps

module issue_dispatch #(
    parameter int ROB_DEPTH  = 8,
    parameter int NUM_UNITS  = 3,
    parameter int UNIT_DEPTH = 2,
    localparam int TAG_W     = $clog2(ROB_DEPTH),
    localparam int CNT_W     = $clog2(ROB_DEPTH + 1),
    localparam int CR_W      = $clog2(UNIT_DEPTH + 1),
    localparam int UNIT_W    = (NUM_UNITS > 1) ? $clog2(NUM_UNITS) : 1
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  ooo_pkg::opcode_t  in_opcode,
    input  ooo_pkg::reg_idx_t in_dest,
    input  ooo_pkg::word_t    in_a,
    input  ooo_pkg::word_t    in_b,
    output logic              alloc_valid,
    output ooo_pkg::reg_idx_t alloc_dest,
    input  logic [TAG_W-1:0]  alloc_tag,
    issue_if.dispatch         units [NUM_UNITS]
);

    // instruction queue, one slot per rob entry
    ooo_pkg::opcode_t q_opcode [ROB_DEPTH];
    logic [TAG_W-1:0] q_tag [ROB_DEPTH];
    ooo_pkg::word_t   q_a [ROB_DEPTH];
    ooo_pkg::word_t   q_b [ROB_DEPTH];
    logic [TAG_W-1:0] q_head;
    logic [TAG_W-1:0] q_tail;
    logic [CNT_W-1:0] q_count;

    logic [CR_W-1:0]   credit_cnt [NUM_UNITS];
    logic              unit_credit [NUM_UNITS];
    logic [UNIT_W-1:0] last_unit;
    logic [UNIT_W-1:0] issue_sel;
    logic              issue_found;
    logic              issue_go;

    // every accepted instruction takes the rob tail slot
    assign alloc_valid = in_valid;
    assign alloc_dest  = in_dest;

    // round robin search, starting after the unit used last
    always_comb begin
        int cand;
        cand = 0;
        issue_found = 1'b0;
        issue_sel = '0;
        for (int k = 1; k <= NUM_UNITS; k++) begin
            cand = int'(last_unit) + k;
            if (cand >= NUM_UNITS) begin
                cand = cand - NUM_UNITS;
            end
            if (!issue_found && credit_cnt[cand] != '0) begin
                issue_found = 1'b1;
                issue_sel = UNIT_W'(cand);
            end
        end
    end

    assign issue_go = (q_count != '0) && issue_found;

    for (genvar g = 0; g < NUM_UNITS; g++) begin : g_unit_port
        // payload goes to every unit, only the chosen one sees valid
        assign units[g].valid  = issue_go && (issue_sel == UNIT_W'(g));
        assign units[g].opcode = q_opcode[q_head];
        assign units[g].tag    = q_tag[q_head];
        assign units[g].a      = q_a[q_head];
        assign units[g].b      = q_b[q_head];
        assign unit_credit[g]  = units[g].credit;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_head <= '0;
            q_tail <= '0;
            q_count <= '0;
            last_unit <= UNIT_W'(NUM_UNITS - 1);
            for (int u = 0; u < NUM_UNITS; u++) begin
                credit_cnt[u] <= CR_W'(UNIT_DEPTH);
            end
        end else begin
            if (in_valid) begin
                q_tail <= q_tail + 1'b1;
            end
            if (issue_go) begin
                q_head <= q_head + 1'b1;
                last_unit <= issue_sel;
            end
            if (in_valid && !issue_go) begin
                q_count <= q_count + 1'b1;
            end else if (!in_valid && issue_go) begin
                q_count <= q_count - 1'b1;
            end
            // take a credit on issue, return one on each unit result
            for (int u = 0; u < NUM_UNITS; u++) begin
                if (issue_go && issue_sel == UNIT_W'(u) && !unit_credit[u]) begin
                    credit_cnt[u] <= credit_cnt[u] - 1'b1;
                end else if (unit_credit[u] && !(issue_go && issue_sel == UNIT_W'(u))) begin
                    credit_cnt[u] <= credit_cnt[u] + 1'b1;
                end
            end
        end
    end

    // queue payload
    always_ff @(posedge clk) begin
        if (in_valid) begin
            q_opcode[q_tail] <= in_opcode;
            q_tag[q_tail] <= alloc_tag;
            q_a[q_tail] <= in_a;
            q_b[q_tail] <= in_b;
        end
    end

endmodule : issue_dispatch

//--- hdl/issue_if.sv
`timescale 1ns/1ps

interface issue_if #(
    parameter int TAG_W = 3
);

    // operation payload, driven by the dispatcher
    logic                 valid;
    ooo_pkg::opcode_t     opcode;
    logic [TAG_W-1:0]     tag;
    ooo_pkg::word_t       a;
    ooo_pkg::word_t       b;

    // one pulse per operation that has left the unit queue
    logic                 credit;

    modport dispatch (
        output valid, opcode, tag, a, b,
        input  credit
    );

    modport unit (
        input  valid, opcode, tag, a, b,
        output credit
    );

endinterface : issue_if

//--- hdl/ooo_core_top.sv
`timescale 1ns/1ps

module ooo_core_top #(
    parameter int ROB_DEPTH  = 8,
    parameter int NUM_UNITS  = 3,
    parameter int UNIT_DEPTH = 2,
    parameter int MUL_CYCLES = 4,
    localparam int TAG_W     = $clog2(ROB_DEPTH)
) (
    input  logic              clk,
    input  logic              rst_n,
    // instruction source
    input  logic              in_valid,
    input  ooo_pkg::opcode_t  in_opcode,
    input  ooo_pkg::reg_idx_t in_dest,
    input  ooo_pkg::word_t    in_a,
    input  ooo_pkg::word_t    in_b,
    output logic              in_credit,
    // commit port
    output logic              commit_valid,
    output ooo_pkg::reg_idx_t commit_dest,
    output ooo_pkg::word_t    commit_value
);

    logic              alloc_valid;
    ooo_pkg::reg_idx_t alloc_dest;
    logic [TAG_W-1:0]  alloc_tag;

    logic              unit_result_valid [NUM_UNITS];
    logic [TAG_W-1:0]  unit_result_tag [NUM_UNITS];
    ooo_pkg::word_t    unit_result_value [NUM_UNITS];

    issue_if #(.TAG_W(TAG_W)) issue_bus [NUM_UNITS] ();

    // a committed entry frees one rob slot for the source
    assign in_credit = commit_valid;

    issue_dispatch #(
        .ROB_DEPTH  (ROB_DEPTH),
        .NUM_UNITS  (NUM_UNITS),
        .UNIT_DEPTH (UNIT_DEPTH)
    ) issue_dispatch_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_opcode   (in_opcode),
        .in_dest     (in_dest),
        .in_a        (in_a),
        .in_b        (in_b),
        .alloc_valid (alloc_valid),
        .alloc_dest  (alloc_dest),
        .alloc_tag   (alloc_tag),
        .units       (issue_bus)
    );

    for (genvar u = 0; u < NUM_UNITS; u++) begin : g_unit
        exec_unit #(
            .ROB_DEPTH  (ROB_DEPTH),
            .UNIT_DEPTH (UNIT_DEPTH),
            .MUL_CYCLES (MUL_CYCLES)
        ) exec_unit_inst (
            .clk          (clk),
            .rst_n        (rst_n),
            .issue        (issue_bus[u]),
            .result_valid (unit_result_valid[u]),
            .result_tag   (unit_result_tag[u]),
            .result_value (unit_result_value[u])
        );
    end

    reorder_buffer #(
        .ROB_DEPTH (ROB_DEPTH),
        .NUM_UNITS (NUM_UNITS)
    ) reorder_buffer_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .alloc_valid  (alloc_valid),
        .alloc_dest   (alloc_dest),
        .alloc_tag    (alloc_tag),
        .result_valid (unit_result_valid),
        .result_tag   (unit_result_tag),
        .result_value (unit_result_value),
        .commit_valid (commit_valid),
        .commit_dest  (commit_dest),
        .commit_value (commit_value)
    );

endmodule : ooo_core_top

//--- hdl/ooo_pkg.sv
package ooo_pkg;

    // data path widths
    localparam int WORD_W = 32;
    localparam int REG_W  = 5;

    // operand and result word
    typedef logic [WORD_W-1:0] word_t;

    // destination register index
    typedef logic [REG_W-1:0] reg_idx_t;

    // register-to-register operations
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_XOR = 3'd3,
        OP_SLT = 3'd4,  // signed compare, result is 0 or 1
        OP_MUL = 3'd5   // low word of the product
    } opcode_t;

endpackage : ooo_pkg

//--- hdl/reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer #(
    parameter int ROB_DEPTH = 8,
    parameter int NUM_UNITS = 3,
    localparam int TAG_W    = $clog2(ROB_DEPTH)
) (
    input  logic              clk,
    input  logic              rst_n,
    // allocation from the dispatcher
    input  logic              alloc_valid,
    input  ooo_pkg::reg_idx_t alloc_dest,
    output logic [TAG_W-1:0]  alloc_tag,
    // results from the execution units
    input  logic              result_valid [NUM_UNITS],
    input  logic [TAG_W-1:0]  result_tag [NUM_UNITS],
    input  ooo_pkg::word_t    result_value [NUM_UNITS],
    // in-order commit
    output logic              commit_valid,
    output ooo_pkg::reg_idx_t commit_dest,
    output ooo_pkg::word_t    commit_value
);

    // entry state
    logic [ROB_DEPTH-1:0] busy;   // allocated and not yet committed
    logic [ROB_DEPTH-1:0] ready;  // result has arrived

    // entry payload
    ooo_pkg::reg_idx_t rob_dest [ROB_DEPTH];
    ooo_pkg::word_t    rob_value [ROB_DEPTH];

    logic [TAG_W-1:0] head;  // oldest entry, next to commit
    logic [TAG_W-1:0] tail;  // next entry to hand out

    // tag for the instruction being accepted this cycle
    assign alloc_tag = tail;

    // head retires as soon as its result is in
    assign commit_valid = busy[head] && ready[head];
    assign commit_dest  = rob_dest[head];
    assign commit_value = rob_value[head];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= '0;
            ready <= '0;
            head <= '0;
            tail <= '0;
        end else begin
            if (alloc_valid) begin
                busy[tail] <= 1'b1;
                ready[tail] <= 1'b0;
                tail <= tail + 1'b1;
            end

            // every tag in flight is distinct, so units never collide
            for (int u = 0; u < NUM_UNITS; u++) begin
                if (result_valid[u]) begin
                    ready[result_tag[u]] <= 1'b1;
                end
            end

            if (commit_valid) begin
                busy[head] <= 1'b0;
                ready[head] <= 1'b0;
                head <= head + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_valid) begin
            rob_dest[tail] <= alloc_dest;
        end
        for (int u = 0; u < NUM_UNITS; u++) begin
            if (result_valid[u]) begin
                rob_value[result_tag[u]] <= result_value[u];
            end
        end
    end

endmodule : reorder_buffer

//--- project.f
hdl/ooo_pkg.sv
hdl/issue_if.sv
hdl/issue_dispatch.sv
hdl/exec_unit.sv
hdl/reorder_buffer.sv
hdl/ooo_core_top.sv
verification/ooo_core_assertions.sv
verification/tb_ooo_core.sv

//--- verification/ooo_core_assertions.sv
`timescale 1ns/1ps

module ooo_core_assertions #(
    parameter int ROB_DEPTH = 8,
    parameter int NUM_UNITS = 3,
    localparam int TAG_W    = $clog2(ROB_DEPTH)
) (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 alloc_valid,
    input logic [TAG_W-1:0]     tail,
    input logic [TAG_W-1:0]     head,
    input logic [ROB_DEPTH-1:0] busy,
    input logic [ROB_DEPTH-1:0] ready,
    input logic                 result_valid [NUM_UNITS],
    input logic [TAG_W-1:0]     result_tag [NUM_UNITS]
);

    // a new entry never lands on one in flight, so occupancy stays within the depth
    assert property (@(posedge clk) disable iff (!rst_n) alloc_valid |-> !busy[tail])
        else $error("rob allocation into an occupied entry");

    // ready only ever marks an entry in flight, so a ready head is always a busy one
    assert property (@(posedge clk) disable iff (!rst_n) (ready & ~busy) == '0)
        else $error("rob entry %0d marked ready while free", head);

    for (genvar u = 0; u < NUM_UNITS; u++) begin : g_result
        assert property (@(posedge clk) disable iff (!rst_n)
            result_valid[u] |-> busy[result_tag[u]])
            else $error("unit %0d wrote a result to a free rob entry", u);
    end

endmodule : ooo_core_assertions

bind reorder_buffer ooo_core_assertions #(
    .ROB_DEPTH (ROB_DEPTH),
    .NUM_UNITS (NUM_UNITS)
) ooo_core_assertions_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .alloc_valid  (alloc_valid),
    .tail         (tail),
    .head         (head),
    .busy         (busy),
    .ready        (ready),
    .result_valid (result_valid),
    .result_tag   (result_tag)
);

//--- verification/tb_ooo_core.sv
`timescale 1ns/1ps

module tb_ooo_core;

    localparam int ROB_DEPTH      = 8;
    localparam int NUM_UNITS      = 3;
    localparam int UNIT_DEPTH     = 2;
    localparam int MUL_CYCLES     = 4;
    localparam int NUM_EDGE       = 10;
    localparam int NUM_ORDER      = 5;
    localparam int NUM_RANDOM     = 300;
    localparam int NUM_INSTR      = NUM_EDGE + NUM_ORDER + ROB_DEPTH + NUM_RANDOM;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * (MUL_CYCLES + 4) + 200;

    logic              clk;
    logic              rst_n;
    logic              in_valid;
    ooo_pkg::opcode_t  in_opcode;
    ooo_pkg::reg_idx_t in_dest;
    ooo_pkg::word_t    in_a;
    ooo_pkg::word_t    in_b;
    logic              in_credit;
    logic              commit_valid;
    ooo_pkg::reg_idx_t commit_dest;
    ooo_pkg::word_t    commit_value;

    // expected commits in program order
    ooo_pkg::reg_idx_t exp_dest_q [$];
    ooo_pkg::word_t    exp_value_q [$];

    int credits_used     = 0;
    int credits_returned = 0;
    int min_credits      = ROB_DEPTH;
    int commit_count     = 0;
    int cycle_count      = 0;
    int seed;

    ooo_core_top #(
        .ROB_DEPTH  (ROB_DEPTH),
        .NUM_UNITS  (NUM_UNITS),
        .UNIT_DEPTH (UNIT_DEPTH),
        .MUL_CYCLES (MUL_CYCLES)
    ) ooo_core_top_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_opcode    (in_opcode),
        .in_dest      (in_dest),
        .in_a         (in_a),
        .in_b         (in_b),
        .in_credit    (in_credit),
        .commit_valid (commit_valid),
        .commit_dest  (commit_dest),
        .commit_value (commit_value)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic ooo_pkg::word_t expected_result(input ooo_pkg::opcode_t op,
                                                       input ooo_pkg::word_t a,
                                                       input ooo_pkg::word_t b);
        logic [63:0] product;
        product = {32'd0, a} * {32'd0, b};
        case (op)
            ooo_pkg::OP_ADD: return a + b;
            ooo_pkg::OP_SUB: return a + ~b + 32'd1;
            ooo_pkg::OP_AND: return a & b;
            ooo_pkg::OP_XOR: return a ^ b;
            ooo_pkg::OP_SLT: begin
                // with different signs the negative operand is the smaller one
                if (a[31] != b[31]) begin
                    return {31'd0, a[31]};
                end
                return {31'd0, a < b};
            end
            ooo_pkg::OP_MUL: return product[31:0];
            default:         return '0;
        endcase
    endfunction

    task automatic abort_run();
        $display("Checks failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic expect_true(input bit cond, input string what);
        if (!cond) begin
            $display("%s", what);
            abort_run();
        end
    endtask

    task automatic check_value(input string name, input ooo_pkg::word_t actual,
                               input ooo_pkg::word_t expected);
        if (actual !== expected) begin
            $display("ERROR %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_dest(input string name, input ooo_pkg::reg_idx_t actual,
                              input ooo_pkg::reg_idx_t expected);
        if (actual !== expected) begin
            $display("ERROR %s: got 0x%02h, expected 0x%02h", name, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            abort_run();
        end
    endtask

    // one instruction, sent only while the source holds a credit
    task automatic send(input ooo_pkg::opcode_t op, input ooo_pkg::reg_idx_t dest,
                        input ooo_pkg::word_t a, input ooo_pkg::word_t b);
        while (ROB_DEPTH + credits_returned - credits_used <= 0) begin
            @(negedge clk);
        end
        in_valid = 1'b1;
        in_opcode = op;
        in_dest = dest;
        in_a = a;
        in_b = b;
        credits_used++;
        if (ROB_DEPTH + credits_returned - credits_used < min_credits) begin
            min_credits = ROB_DEPTH + credits_returned - credits_used;
        end
        exp_dest_q.push_back(dest);
        exp_value_q.push_back(expected_result(op, a, b));
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_dest_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
    endtask

    // commit checker, sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            check_flag("in_credit", in_credit, commit_valid);
            if (commit_valid) begin
                expect_true(exp_dest_q.size() != 0, "commit seen with nothing outstanding");
                check_dest("commit_dest", commit_dest, exp_dest_q.pop_front());
                check_value("commit_value", commit_value, exp_value_q.pop_front());
                commit_count++;
            end
            // each in_credit pulse hands one rob slot back to the source
            if (in_credit) begin
                credits_returned <= credits_returned + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    initial begin
        ooo_pkg::opcode_t  op;
        ooo_pkg::reg_idx_t dest;
        ooo_pkg::word_t    a;
        ooo_pkg::word_t    b;
        int                pick;
        int                gap;
        bit                end_ok;
        seed = 48623;
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_opcode = ooo_pkg::OP_ADD;
        in_dest = '0;
        in_a = '0;
        in_b = '0;
        repeat (3) begin
            @(negedge clk);
            check_flag("commit_valid", commit_valid, 1'b0);
            check_flag("in_credit", in_credit, 1'b0);
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_flag("commit_valid", commit_valid, 1'b0);
        check_flag("in_credit", in_credit, 1'b0);

        // every opcode with edge operands
        send(ooo_pkg::OP_ADD, 5'd1, 32'h7fff_ffff, 32'd1);
        send(ooo_pkg::OP_ADD, 5'd2, 32'hffff_ffff, 32'd1);
        send(ooo_pkg::OP_SUB, 5'd3, 32'd0, 32'd1);
        send(ooo_pkg::OP_SUB, 5'd4, 32'h8000_0000, 32'd1);
        send(ooo_pkg::OP_AND, 5'd5, 32'hffff_ffff, 32'h0f0f_0f0f);
        send(ooo_pkg::OP_XOR, 5'd6, 32'ha5a5_a5a5, 32'ha5a5_a5a5);
        send(ooo_pkg::OP_SLT, 5'd7, 32'hffff_ffff, 32'd1);
        send(ooo_pkg::OP_SLT, 5'd8, 32'd1, 32'hffff_ffff);
        send(ooo_pkg::OP_MUL, 5'd9, 32'hffff_ffff, 32'hffff_ffff);
        send(ooo_pkg::OP_MUL, 5'd31, 32'd0, 32'hdead_beef);
        wait_drain();

        // younger additions finish before the multiply but commit after it
        send(ooo_pkg::OP_MUL, 5'd12, 32'd3, 32'd7);
        for (int i = 0; i < NUM_ORDER - 1; i++) begin
            send(ooo_pkg::OP_ADD, 5'(13 + i), 32'(i), 32'(100 * i));
        end
        wait_drain();

        // fill the rob back to back behind a multiply
        min_credits = ROB_DEPTH;
        send(ooo_pkg::OP_MUL, 5'd20, 32'h1234, 32'h5678);
        for (int i = 1; i < ROB_DEPTH; i++) begin
            send(ooo_pkg::OP_ADD, 5'(20 + i), 32'(i), 32'(i));
        end
        expect_true(min_credits == 0, "the burst never used up the source credits");
        wait_drain();

        for (int n = 0; n < NUM_RANDOM; n++) begin
            pick = $unsigned($random(seed)) % 6;
            op = ooo_pkg::opcode_t'(pick[2:0]);
            dest = ooo_pkg::reg_idx_t'($unsigned($random(seed)));
            a = $random(seed);
            b = $random(seed);
            send(op, dest, a, b);
            gap = $unsigned($random(seed)) % 4;
            repeat (gap) @(negedge clk);
        end
        wait_drain();

        end_ok = (exp_dest_q.size() == 0) && (commit_count == NUM_INSTR) &&
                 (credits_returned == credits_used);
        if (end_ok) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("%0d of %0d instructions committed, %0d credits back for %0d sent",
                     commit_count, NUM_INSTR, credits_returned, credits_used);
            abort_run();
        end
    end

endmodule : tb_ooo_core
